//--- filelist.f
hw/isa_pkg.sv
hw/exec_pkg.sv
hw/issue_if.sv
hw/result_if.sv
hw/issue_dispatch.sv
hw/seq_divider.sv
hw/alu_lane.sv
hw/result_arbiter.sv
hw/exec_cluster.sv
tests/clk_gen.sv
tests/exec_cluster_props.sv
tests/tb_exec_cluster.sv

//--- Makefile
# Verilator build and run for the execute cluster testbench

VERILATOR ?= verilator
TOP ?= tb_exec_cluster
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -q '^Simulation PASSED$$' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_exec_cluster.sv
/*
 * Testbench for the execute cluster. Issues random and corner case
 * operations with fresh tags and checks every tagged result.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_exec_cluster;
	import isa_pkg::*;
	import exec_pkg::*;

	localparam int NUM_LANES = 4;
	localparam int NUM_TAGS = 16;
	localparam int WAIT_LIMIT = 1000;
	localparam value_t MIN_VAL = 64'h8000_0000_0000_0000;
	localparam value_t MAX_VAL = 64'h7FFF_FFFF_FFFF_FFFF;

	logic clk;
	logic arst_n;
	logic issue;
	instruction_t issue_ir;
	value_t issue_a, issue_b, issue_c, issue_t, issue_i, issue_p;
	tag_t issue_tag;
	logic full;
	logic res_valid;
	tag_t res_tag;
	value_t res_value;
	logic res_dbz;

	// Expected result per tag, written when the tag is issued
	value_t exp_value [NUM_TAGS] = '{default: '0};
	logic exp_dbz [NUM_TAGS] = '{default: 1'b0};
	// A tag is outstanding while its issue and return toggles differ
	logic issue_seq [NUM_TAGS] = '{default: 1'b0};
	logic ret_seq [NUM_TAGS] = '{default: 1'b0};
	// Order in which each tag last came back
	int ret_stamp [NUM_TAGS] = '{default: 0};
	int ret_count = 0;
	tag_t next_tag = '0;

	func_t r2_fns [25] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND,
		FN_NOR, FN_ENOR, FN_ORC, FN_CMP, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU,
		FN_SLEU, FN_MUL, FN_MULU, FN_MULH, FN_MULUH, FN_DIV, FN_DIVU, FN_MOD, FN_MODU};
	opcode_t imm_ops [13] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_EORI, OP_SLTI, OP_CMPI,
		OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI, OP_MOV, OP_LDX, OP_BLEND};
	func_t mul_fns [4] = '{FN_MUL, FN_MULU, FN_MULH, FN_MULUH};
	func_t div_fns [4] = '{FN_DIV, FN_DIVU, FN_MOD, FN_MODU};

	clk_gen u_clk_gen (
		.clk   (clk),
		.arst_n(arst_n)
	);

	exec_cluster #(.NUM_LANES(NUM_LANES)) u_exec_cluster (
		.clk      (clk),
		.arst_n   (arst_n),
		.issue    (issue),
		.issue_ir (issue_ir),
		.issue_a  (issue_a),
		.issue_b  (issue_b),
		.issue_c  (issue_c),
		.issue_t  (issue_t),
		.issue_i  (issue_i),
		.issue_p  (issue_p),
		.issue_tag(issue_tag),
		.full     (full),
		.res_valid(res_valid),
		.res_tag  (res_tag),
		.res_value(res_value),
		.res_dbz  (res_dbz)
	);

	bind exec_cluster exec_cluster_props u_props (
		.clk      (clk),
		.arst_n   (arst_n),
		.issue    (issue),
		.issue_tag(issue_tag),
		.full     (full),
		.res_valid(res_valid),
		.res_tag  (res_tag)
	);

	// ======================================================================
	// Result checking
	// ======================================================================
	always @(posedge clk)
		if (res_valid)
		begin
			ret_seq[res_tag] <= ~ret_seq[res_tag];
			ret_stamp[res_tag] <= ret_count;
			ret_count <= ret_count + 1;
		end

	a_value: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> res_value == exp_value[res_tag])
		else
		begin
			$display("Error: res_value for tag %h is %h, expected %h", $sampled(res_tag),
				$sampled(res_value), exp_value[$sampled(res_tag)]);
			$display("Simulation FAILED");
			$fatal(1, "result value mismatch");
		end

	a_dbz: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> res_dbz == exp_dbz[res_tag])
		else
		begin
			$display("Error: res_dbz for tag %h is %h, expected %h", $sampled(res_tag),
				$sampled(res_dbz), exp_dbz[$sampled(res_tag)]);
			$display("Simulation FAILED");
			$fatal(1, "divide by zero flag mismatch");
		end

	// ======================================================================
	// Reference model
	// ======================================================================
	function automatic value_t rand64();
		return {$urandom(), $urandom()};
	endfunction

	function automatic instruction_t make_insn(opcode_t opc, func_t fn);
		instruction_t ir;
		ir = '0;
		ir[OPCODE_LSB +: $bits(opcode_t)] = opc;
		ir[FUNC_LSB +: $bits(func_t)] = fn;
		return ir;
	endfunction

	// Zero divisor gives all ones and the dividend, MIN over -1 wraps to MIN
	function automatic void div_model(input value_t a, input value_t b, input logic sgn,
		output value_t q, output value_t r);
		if (b == '0)
		begin
			q = '1;
			r = a;
		end
		else if (sgn && a == MIN_VAL && b == '1)
		begin
			q = MIN_VAL;
			r = '0;
		end
		else if (sgn)
		begin
			q = value_t'($signed(a) / $signed(b));
			r = value_t'($signed(a) % $signed(b));
		end
		else
		begin
			q = a / b;
			r = a % b;
		end
	endfunction

	// Compare flags, one per bit: equal, signed less-than, unsigned less-than
	function automatic value_t cmp_model(value_t a, value_t b);
		value_t v;
		v = '0;
		v[0] = (a == b);
		v[1] = ($signed(a) < $signed(b));
		v[2] = (a < b);
		return v;
	endfunction

	// Each mask bit in c picks b when set and a when clear
	function automatic value_t blend_model(value_t a, value_t b, value_t c);
		value_t v;
		for (int k = 0; k < $bits(value_t); k++)
			v[k] = c[k] ? b[k] : a[k];
		return v;
	endfunction

	function automatic value_t model_value(instruction_t ir, value_t a, value_t b,
		value_t c, value_t t, value_t i, value_t p);
		opcode_t opc;
		func_t fn;
		double_value_t ps;
		double_value_t pu;
		value_t qs, rs, qu, ru;
		opc = ir[OPCODE_LSB +: $bits(opcode_t)];
		fn = ir[FUNC_LSB +: $bits(func_t)];
		// Full products from operands widened to 128 bits
		ps = {{64{a[63]}}, a} * {{64{b[63]}}, b};
		pu = {64'd0, a} * {64'd0, b};
		div_model(a, b, 1'b1, qs, rs);
		div_model(a, b, 1'b0, qu, ru);
		if (!p[0])
			return t;
		case (opc)
		OP_R2:
			case (fn)
			FN_ADD: return a + b;
			FN_SUB: return a - b;
			FN_AND: return a & b;
			FN_OR: return a | b;
			FN_EOR: return a ^ b;
			FN_ANDC: return a & ~b;
			FN_NAND: return ~(a & b);
			FN_NOR: return ~(a | b);
			FN_ENOR: return ~(a ^ b);
			FN_ORC: return a | ~b;
			FN_CMP: return cmp_model(a, b);
			FN_SEQ: return {63'd0, a == b};
			FN_SNE: return {63'd0, a != b};
			FN_SLT: return {63'd0, $signed(a) < $signed(b)};
			FN_SLE: return {63'd0, $signed(a) <= $signed(b)};
			FN_SLTU: return {63'd0, a < b};
			FN_SLEU: return {63'd0, a <= b};
			FN_MUL: return ps[63:0];
			FN_MULU: return pu[63:0];
			FN_MULH: return ps[127:64];
			FN_MULUH: return pu[127:64];
			FN_DIV: return qs;
			FN_DIVU: return qu;
			FN_MOD: return rs;
			FN_MODU: return ru;
			default: return BAD_RESULT;
			endcase
		OP_ADDI: return a + b;
		OP_ANDI: return a & b;
		OP_ORI: return a | b;
		OP_EORI: return a ^ b;
		OP_SLTI: return {63'd0, $signed(a) < $signed(b)};
		OP_CMPI: return cmp_model(a, b);
		OP_MULI: return ps[63:0];
		OP_MULUI: return pu[63:0];
		OP_DIVI: return qs;
		OP_DIVUI: return qu;
		OP_MOV: return a;
		OP_LDX: return a + b + i;
		OP_BLEND: return blend_model(a, b, c);
		default: return BAD_RESULT;
		endcase
	endfunction

	function automatic logic model_dbz(instruction_t ir, value_t b, value_t p);
		opcode_t opc;
		func_t fn;
		logic is_div;
		opc = ir[OPCODE_LSB +: $bits(opcode_t)];
		fn = ir[FUNC_LSB +: $bits(func_t)];
		is_div = (opc == OP_DIVI) || (opc == OP_DIVUI) || ((opc == OP_R2) &&
			(fn == FN_DIV || fn == FN_DIVU || fn == FN_MOD || fn == FN_MODU));
		return p[0] && is_div && (b == '0);
	endfunction

	function automatic int pending_count();
		int cnt;
		cnt = 0;
		for (int k = 0; k < NUM_TAGS; k++)
			if (issue_seq[k] != ret_seq[k])
				cnt++;
		return cnt;
	endfunction

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	endtask

	// Called on a falling edge, returns on the falling edge after the strobe
	task automatic issue_op(input instruction_t ir, input value_t a, input value_t b,
		input value_t c, input value_t t, input value_t i, input value_t p);
		tag_t tag;
		int n;
		tag = next_tag;
		next_tag = next_tag + 1'b1;
		n = 0;
		// A tag is reused only once its last result has come back
		while (issue_seq[tag] != ret_seq[tag])
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("a free result tag");
		end
		n = 0;
		while (full)
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("full to drop");
		end
		exp_value[tag] = model_value(ir, a, b, c, t, i, p);
		exp_dbz[tag] = model_dbz(ir, b, p);
		issue_seq[tag] = ~issue_seq[tag];
		issue = 1'b1;
		issue_ir = ir;
		issue_a = a;
		issue_b = b;
		issue_c = c;
		issue_t = t;
		issue_i = i;
		issue_p = p;
		issue_tag = tag;
		@(negedge clk);
		issue = 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (pending_count() != 0)
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("every outstanding tag to return");
		end
	endtask

	initial
	begin
		value_t corner [6];
		value_t div_a [6];
		value_t div_b [6];
		instruction_t pred_ops [9];
		value_t x;
		tag_t first_tag;
		int n;
		void'($urandom(32'h62f8));
		issue = 1'b0;
		issue_ir = '0;
		issue_a = '0;
		issue_b = '0;
		issue_c = '0;
		issue_t = '0;
		issue_i = '0;
		issue_p = '0;
		issue_tag = '0;
		corner = '{MIN_VAL, MAX_VAL, '1, 64'd1, 64'd0, rand64()};
		// Random, negative dividend, negative divisor, both, zero and overflow
		div_a = '{rand64(), -64'd4096, 64'd12345, MIN_VAL + 64'd5, rand64(), MIN_VAL};
		div_b = '{{32'd0, $urandom()}, 64'd7, -64'd10, -64'd3, 64'd0, '1};
		pred_ops = '{make_insn(OP_R2, FN_ADD), make_insn(OP_R2, FN_MUL),
			make_insn(OP_R2, FN_MULUH), make_insn(OP_R2, FN_DIV), make_insn(OP_R2, FN_MODU),
			make_insn(OP_MULI, '0), make_insn(OP_DIVI, '0), make_insn(OP_BLEND, '0),
			make_insn(OP_LDX, '0)};

		n = 0;
		while (!arst_n)
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				report_timeout("reset release");
		end
		@(negedge clk);

		// Every function and immediate opcode, one pass with equal operands
		for (int f = 0; f < 25; f++)
		begin
			repeat (3)
				issue_op(make_insn(OP_R2, r2_fns[f]), rand64(), rand64(), rand64(),
					rand64(), rand64(), rand64() | 64'd1);
			x = rand64();
			issue_op(make_insn(OP_R2, r2_fns[f]), x, x, rand64(), rand64(), rand64(), 64'd1);
		end
		for (int o = 0; o < 13; o++)
			repeat (4)
				issue_op(make_insn(imm_ops[o], '0), rand64(), rand64(), rand64(),
					rand64(), rand64(), rand64() | 64'd1);
		// Unknown function and unknown opcode
		issue_op(make_insn(OP_R2, 6'h3F), rand64(), rand64(), '0, '0, '0, 64'd1);
		issue_op(make_insn(6'h3F, '0), rand64(), rand64(), '0, '0, '0, 64'd1);

		// Multiplies across the signed extremes
		for (int f = 0; f < 4; f++)
			for (int j = 0; j < 6; j++)
				for (int k = 0; k < 6; k++)
					issue_op(make_insn(OP_R2, mul_fns[f]), corner[j], corner[k], '0, '0,
						'0, 64'd1);

		// Divides, including zero divisor and the overflow case
		for (int j = 0; j < 6; j++)
		begin
			for (int f = 0; f < 4; f++)
				issue_op(make_insn(OP_R2, div_fns[f]), div_a[j], div_b[j], '0, '0, '0, 64'd1);
			issue_op(make_insn(OP_DIVI, '0), div_a[j], div_b[j], '0, '0, '0, 64'd1);
			issue_op(make_insn(OP_DIVUI, '0), div_a[j], div_b[j], '0, '0, '0, 64'd1);
		end

		// Predicate off returns t, a zero divisor must not raise dbz
		for (int k = 0; k < 9; k++)
		begin
			issue_op(pred_ops[k], rand64(), 64'd0, rand64(), rand64(), rand64(),
				rand64() & ~64'd1);
			issue_op(pred_ops[k], rand64(), rand64(), rand64(), rand64(), rand64(),
				rand64() & ~64'd1);
		end

		// A long divide on every idle lane leaves none free
		wait_drained();
		for (int k = 0; k < NUM_LANES; k++)
			issue_op(make_insn(OP_R2, FN_DIVU), rand64(), rand64() | 64'd1, '0, '0, '0,
				64'd1);
		assert (full === 1'b1)
		else
		begin
			$display("Error: full is %h, expected %h with every lane busy", full, 1'b1);
			$display("Simulation FAILED");
			$fatal(1, "full flag");
		end

		// One divide then four adds, the adds overtake the divide
		wait_drained();
		first_tag = next_tag;
		issue_op(make_insn(OP_R2, FN_DIV), rand64(), 64'd3, '0, '0, '0, 64'd1);
		repeat (4)
			issue_op(make_insn(OP_R2, FN_ADD), rand64(), rand64(), '0, '0, '0, 64'd1);
		wait_drained();
		for (int k = 1; k <= 4; k++)
			assert (ret_stamp[tag_t'(first_tag + k)] < ret_stamp[first_tag])
			else
			begin
				$display("The divide result came back before the add with tag %h",
					tag_t'(first_tag + k));
				$display("Simulation FAILED");
				$fatal(1, "result order");
			end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/exec_cluster_props.sv
/*
 * Protocol assertions for the execute cluster top level ports.
 * Bound into exec_cluster by the testbench.
 */
`timescale 1ns/100ps
`default_nettype none

module exec_cluster_props
(
	input logic           clk,
	input logic           arst_n,
	input logic           issue,
	input exec_pkg::tag_t issue_tag,
	input logic           full,
	input logic           res_valid,
	input exec_pkg::tag_t res_tag
);
	import exec_pkg::*;

	localparam int NUM_TAGS = 2 ** $bits(tag_t);

	// One bit per tag, set by an accepted issue and cleared by its result
	logic [NUM_TAGS-1:0] outstanding;
	logic [NUM_TAGS-1:0] outstanding_next;

	always_comb
	begin
		outstanding_next = outstanding;
		if (res_valid)
			outstanding_next[res_tag] = 1'b0;
		if (issue && !full)
			outstanding_next[issue_tag] = 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			outstanding <= '0;
		else
			outstanding <= outstanding_next;

	// ======================================================================
	// Port protocol
	// ======================================================================

	// Nothing is reported while the cluster sits in reset
	a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !full && !res_valid)
		else $error("full or res_valid high during reset");

	// Back to back result strobes must belong to two different grants
	a_one_per_grant: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid && $past(res_valid) |-> res_tag != $past(res_tag))
		else $error("res_valid held for a second cycle with the same tag");

	a_no_issue_when_full: assert property (@(posedge clk) disable iff (!arst_n)
		!(issue && full))
		else $error("issue strobe sampled while full was high");

	// A result may only carry a tag that was issued and has not yet come back
	a_tag_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> outstanding[res_tag])
		else $error("res_tag returned that is not outstanding");

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
/*
 * Testbench clock and reset source. 100 ns clock, reset held two cycles.
 */
`timescale 1ns/100ps
`default_nettype none

module clk_gen
(
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD = 50;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset falls shortly after time zero so the asynchronous reset sees an edge
	initial
	begin
		arst_n = 1'b1;
		#10;
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		// Release away from the rising edge
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/exec_cluster.sv
/*
 * Multi-lane integer execute cluster. A dispatcher feeds identical ALU
 * lanes and an arbiter merges their tagged results into one stream.
 */
`timescale 1ns/100ps
`default_nettype none

module exec_cluster #(
	parameter int NUM_LANES = 4
)
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  issue,
	input  isa_pkg::instruction_t issue_ir,
	input  isa_pkg::value_t       issue_a,
	input  isa_pkg::value_t       issue_b,
	input  isa_pkg::value_t       issue_c,
	input  isa_pkg::value_t       issue_t,
	input  isa_pkg::value_t       issue_i,
	input  isa_pkg::value_t       issue_p,
	input  exec_pkg::tag_t        issue_tag,
	output logic                  full,
	output logic                  res_valid,
	output exec_pkg::tag_t        res_tag,
	output isa_pkg::value_t       res_value,
	output logic                  res_dbz
);

	// One issue channel and one result channel per lane
	issue_if iss_bus [NUM_LANES] ();
	result_if res_bus [NUM_LANES] ();

	issue_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
		.clk   (clk),
		.arst_n(arst_n),
		.issue (issue),
		.ir    (issue_ir),
		.a     (issue_a),
		.b     (issue_b),
		.c     (issue_c),
		.t     (issue_t),
		.i     (issue_i),
		.p     (issue_p),
		.tag   (issue_tag),
		.full  (full),
		.lanes (iss_bus)
	);

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		alu_lane u_lane (
			.clk   (clk),
			.arst_n(arst_n),
			.iss   (iss_bus[g]),
			.res   (res_bus[g])
		);
	end

	result_arbiter #(.NUM_LANES(NUM_LANES)) u_arbiter (
		.clk      (clk),
		.arst_n   (arst_n),
		.lanes    (res_bus),
		.res_valid(res_valid),
		.res_tag  (res_tag),
		.res_value(res_value),
		.res_dbz  (res_dbz)
	);

endmodule

`default_nettype wire

//--- hw/result_arbiter.sv
/*
 * Result arbiter. Grants the lowest numbered lane holding a result and
 * registers it onto the single cluster result stream.
 */
`timescale 1ns/100ps
`default_nettype none

module result_arbiter #(
	parameter int NUM_LANES = 4
)
(
	input  logic            clk,
	input  logic            arst_n,
	result_if.arbiter       lanes [NUM_LANES],
	output logic            res_valid,
	output exec_pkg::tag_t  res_tag,
	output isa_pkg::value_t res_value,
	output logic            res_dbz
);
	import isa_pkg::*;
	import exec_pkg::*;

	logic [NUM_LANES-1:0] valid_vec;
	logic [NUM_LANES-1:0] grant;
	logic [NUM_LANES-1:0] dbz_vec;
	tag_t tag_arr [NUM_LANES];
	value_t value_arr [NUM_LANES];
	tag_t sel_tag;
	value_t sel_value;
	logic sel_dbz;

	// Fixed priority, lowest index wins
	assign grant = valid_vec & (~valid_vec + NUM_LANES'(1));

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		assign valid_vec[g] = lanes[g].valid;
		assign tag_arr[g] = lanes[g].tag;
		assign value_arr[g] = lanes[g].value;
		assign dbz_vec[g] = lanes[g].dbz;
		// The granted lane drops its result on the same edge that we capture it
		assign lanes[g].take = grant[g];
	end

	// One-hot grant, so an OR of the gated fields is the mux
	always_comb
	begin
		sel_tag = '0;
		sel_value = '0;
		sel_dbz = 1'b0;
		for (int k = 0; k < NUM_LANES; k++)
			if (grant[k])
			begin
				sel_tag |= tag_arr[k];
				sel_value |= value_arr[k];
				sel_dbz |= dbz_vec[k];
			end
	end

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			res_valid <= 1'b0;
		else
			res_valid <= |valid_vec;

	always_ff @(posedge clk)
		if (|valid_vec)
		begin
			res_tag <= sel_tag;
			res_value <= sel_value;
			res_dbz <= sel_dbz;
		end

endmodule

`default_nettype wire

//--- hw/alu_lane.sv
/*
 * One execute lane. Decodes the operation, runs the multiply pipeline
 * or the divider, applies predication and holds the result until taken.
 */
`timescale 1ns/100ps
`default_nettype none

module alu_lane
(
	input logic   clk,
	input logic   arst_n,
	issue_if.lane iss,
	result_if.lane res
);
	import isa_pkg::*;
	import exec_pkg::*;

	lane_state_t state;
	logic mul_cnt;
	// Decode of the incoming operation, only meaningful during start
	opcode_t iss_opc;
	func_t iss_fn;
	logic iss_mul;
	logic iss_div;
	logic iss_sgn;
	// Latched operation
	instruction_t ir_q;
	value_t a_q, b_q, c_q, t_q, i_q, p_q;
	tag_t tag_q;
	logic div_op_q;
	opcode_t opc;
	func_t fn;
	// Multiplier products and the three pipeline registers
	double_value_t mul_s;
	double_value_t mul_u;
	double_value_t mul_p1, mul_p2, mul_p3;
	value_t div_q, div_r;
	logic div_dbz;
	logic div_done;
	value_t cmpo;
	value_t bus;

	// ======================================================================
	// Multi-cycle classification of the operation being started
	// ======================================================================
	assign iss_opc = iss.ir[OPCODE_LSB +: $bits(opcode_t)];
	assign iss_fn = iss.ir[FUNC_LSB +: $bits(func_t)];

	always_comb
	begin
		iss_mul = 1'b0;
		iss_div = 1'b0;
		iss_sgn = 1'b0;
		case (iss_opc)
		OP_R2:
			case (iss_fn)
			FN_MUL, FN_MULH: {iss_mul, iss_sgn} = 2'b11;
			FN_MULU, FN_MULUH: iss_mul = 1'b1;
			FN_DIV, FN_MOD: {iss_div, iss_sgn} = 2'b11;
			FN_DIVU, FN_MODU: iss_div = 1'b1;
			default: ;
			endcase
		OP_MULI: {iss_mul, iss_sgn} = 2'b11;
		OP_MULUI: iss_mul = 1'b1;
		OP_DIVI: {iss_div, iss_sgn} = 2'b11;
		OP_DIVUI: iss_div = 1'b1;
		default: ;
		endcase
	end

	// Lane FSM. busy covers the start cycle too so the lane is never picked twice
	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
		begin
			state <= LANE_IDLE;
			mul_cnt <= 1'b0;
		end
		else
			case (state)
			LANE_IDLE:
				if (iss.start)
				begin
					mul_cnt <= 1'b0;
					// A predicated-off operation skips the long units
					if (!iss.p[0])
						state <= LANE_HOLD;
					else if (iss_mul)
						state <= LANE_MUL;
					else if (iss_div)
						state <= LANE_DIV;
					else
						state <= LANE_HOLD;
				end
			LANE_MUL:
				begin
					mul_cnt <= 1'b1;
					if (mul_cnt)
						state <= LANE_HOLD;
				end
			LANE_DIV:
				if (div_done)
					state <= LANE_HOLD;
			LANE_HOLD:
				if (res.take)
					state <= LANE_IDLE;
			default: state <= LANE_IDLE;
			endcase

	always_ff @(posedge clk)
		if (iss.start)
		begin
			ir_q <= iss.ir;
			a_q <= iss.a;
			b_q <= iss.b;
			c_q <= iss.c;
			t_q <= iss.t;
			i_q <= iss.i;
			p_q <= iss.p;
			tag_q <= iss.tag;
			div_op_q <= iss_div;
		end

	// ======================================================================
	// Long units, fed straight from the issue fields on start
	// ======================================================================
	assign mul_s = $signed(iss.a) * $signed(iss.b);
	assign mul_u = iss.a * iss.b;

	// Stage one loads once per multiply, the later stages then settle and hold
	always_ff @(posedge clk)
	begin
		if (iss.start && iss_mul && iss.p[0])
			mul_p1 <= iss_sgn ? mul_s : mul_u;
		mul_p2 <= mul_p1;
		mul_p3 <= mul_p2;
	end

	seq_divider u_div (
		.clk   (clk),
		.arst_n(arst_n),
		.ld    (iss.start && iss_div && iss.p[0]),
		.sgn   (iss_sgn),
		.a     (iss.a),
		.b     (iss.b),
		.q     (div_q),
		.r     (div_r),
		.dbz   (div_dbz),
		.done  (div_done)
	);

	// ======================================================================
	// Result select on the latched operation
	// ======================================================================
	assign opc = ir_q[OPCODE_LSB +: $bits(opcode_t)];
	assign fn = ir_q[FUNC_LSB +: $bits(func_t)];
	// bit 0 equal, bit 1 signed less-than, bit 2 unsigned less-than
	assign cmpo = {61'd0, a_q < b_q, $signed(a_q) < $signed(b_q), a_q == b_q};

	always_comb
		case (opc)
		OP_R2:
			case (fn)
			FN_ADD: bus = a_q + b_q;
			FN_SUB: bus = a_q - b_q;
			FN_CMP: bus = cmpo;
			FN_AND: bus = a_q & b_q;
			FN_OR: bus = a_q | b_q;
			FN_EOR: bus = a_q ^ b_q;
			FN_ANDC: bus = a_q & ~b_q;
			FN_NAND: bus = ~(a_q & b_q);
			FN_NOR: bus = ~(a_q | b_q);
			FN_ENOR: bus = ~(a_q ^ b_q);
			FN_ORC: bus = a_q | ~b_q;
			FN_SEQ: bus = value_t'(a_q == b_q);
			FN_SNE: bus = value_t'(a_q != b_q);
			FN_SLT: bus = value_t'($signed(a_q) < $signed(b_q));
			FN_SLE: bus = value_t'($signed(a_q) <= $signed(b_q));
			FN_SLTU: bus = value_t'(a_q < b_q);
			FN_SLEU: bus = value_t'(a_q <= b_q);
			FN_MUL, FN_MULU: bus = mul_p3[63:0];
			FN_MULH, FN_MULUH: bus = mul_p3[127:64];
			FN_DIV, FN_DIVU: bus = div_q;
			FN_MOD, FN_MODU: bus = div_r;
			default: bus = BAD_RESULT;
			endcase
		OP_ADDI: bus = a_q + b_q;
		OP_CMPI: bus = cmpo;
		OP_MULI, OP_MULUI: bus = mul_p3[63:0];
		OP_DIVI, OP_DIVUI: bus = div_q;
		OP_ANDI: bus = a_q & b_q;
		OP_ORI: bus = a_q | b_q;
		OP_EORI: bus = a_q ^ b_q;
		OP_SLTI: bus = value_t'($signed(a_q) < $signed(b_q));
		OP_MOV: bus = a_q;
		OP_LDX: bus = a_q + b_q + i_q;
		// b where the mask in c is set, a elsewhere
		OP_BLEND: bus = (b_q & c_q) | (a_q & ~c_q);
		default: bus = BAD_RESULT;
		endcase

	assign iss.busy = iss.start || (state != LANE_IDLE);
	assign res.valid = (state == LANE_HOLD);
	assign res.tag = tag_q;
	// Predicate off returns the old target value
	assign res.value = p_q[0] ? bus : t_q;
	assign res.dbz = p_q[0] && div_op_q && div_dbz;

endmodule

`default_nettype wire

//--- hw/seq_divider.sv
/*
 * Restoring divider, signed or unsigned, one quotient bit per cycle.
 * A zero divisor returns all ones and the dividend and sets dbz.
 */
`timescale 1ns/100ps
`default_nettype none

module seq_divider
(
	input  logic            clk,
	input  logic            arst_n,
	input  logic            ld,
	input  logic            sgn,
	input  isa_pkg::value_t a,
	input  isa_pkg::value_t b,
	output isa_pkg::value_t q,
	output isa_pkg::value_t r,
	output logic            dbz,
	output logic            done
);
	import isa_pkg::*;
	import exec_pkg::*;

	localparam int W = $bits(value_t);

	div_state_t state;
	logic [5:0] cnt;
	// quo starts as the dividend magnitude and fills up with quotient bits
	value_t quo;
	value_t rem;
	value_t dvs;
	logic neg_q;
	logic neg_r;
	logic [W:0] shifted;
	logic [W:0] diff;
	logic ge;

	// One restoring step, shift in the next dividend bit and trial subtract
	assign shifted = {rem, quo[W-1]};
	assign diff = shifted - {1'b0, dvs};
	assign ge = shifted >= {1'b0, dvs};

	// The load cycle is the setup cycle, then 64 steps and one done cycle
	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
		begin
			state <= DIV_IDLE;
			cnt <= '0;
			dbz <= 1'b0;
		end
		else if (ld)
		begin
			state <= DIV_RUN;
			cnt <= '0;
			dbz <= (b == '0);
		end
		else
			case (state)
			DIV_RUN:
				begin
					cnt <= cnt + 6'd1;
					if (cnt == 6'd63)
						state <= DIV_DONE;
				end
			DIV_DONE: state <= DIV_IDLE;
			default: state <= DIV_IDLE;
			endcase

	always_ff @(posedge clk)
		if (ld)
		begin
			quo <= (sgn && a[W-1]) ? -a : a;
			dvs <= (sgn && b[W-1]) ? -b : b;
			rem <= '0;
			// A zero divisor keeps the all ones quotient unsigned
			neg_q <= sgn && (a[W-1] ^ b[W-1]) && (b != '0);
			neg_r <= sgn && a[W-1];
		end
		else if (state == DIV_RUN)
		begin
			quo <= {quo[W-2:0], ge};
			rem <= ge ? diff[W-1:0] : shifted[W-1:0];
		end

	// Sign fix. The most negative dividend over minus one wraps to itself
	assign q = neg_q ? -quo : quo;
	assign r = neg_r ? -rem : rem;
	assign done = (state == DIV_DONE);

endmodule

`default_nettype wire

//--- hw/issue_dispatch.sv
/*
 * Issue dispatcher. Routes each issue strobe to the lowest numbered
 * idle lane and reports full when every lane is busy.
 */
`timescale 1ns/100ps
`default_nettype none

module issue_dispatch #(
	parameter int NUM_LANES = 4
)
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  issue,
	input  isa_pkg::instruction_t ir,
	input  isa_pkg::value_t       a,
	input  isa_pkg::value_t       b,
	input  isa_pkg::value_t       c,
	input  isa_pkg::value_t       t,
	input  isa_pkg::value_t       i,
	input  isa_pkg::value_t       p,
	input  exec_pkg::tag_t        tag,
	output logic                  full,
	issue_if.dispatch             lanes [NUM_LANES]
);

	logic [NUM_LANES-1:0] busy_vec;
	logic [NUM_LANES-1:0] idle_vec;
	logic [NUM_LANES-1:0] grant;
	logic accept;

	// Lowest set bit of the idle vector picks the lane
	assign idle_vec = ~busy_vec;
	assign grant = idle_vec & (~idle_vec + NUM_LANES'(1));
	assign full = &busy_vec;
	// An issue seen while full is dropped
	assign accept = issue && !full;

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		assign busy_vec[g] = lanes[g].busy;

		// The start strobe lasts one cycle since busy rises with it
		always_ff @(posedge clk or negedge arst_n)
			if (!arst_n)
				lanes[g].start <= 1'b0;
			else
				lanes[g].start <= accept && grant[g];

		// Operand fields only load for the granted lane
		always_ff @(posedge clk)
			if (accept && grant[g])
			begin
				lanes[g].ir <= ir;
				lanes[g].a <= a;
				lanes[g].b <= b;
				lanes[g].c <= c;
				lanes[g].t <= t;
				lanes[g].i <= i;
				lanes[g].p <= p;
				lanes[g].tag <= tag;
			end
	end

endmodule

`default_nettype wire

//--- hw/result_if.sv
/*
 * Result channel from one execute lane to the result arbiter
 */
`timescale 1ns/100ps
`default_nettype none

interface result_if;
	import isa_pkg::*;
	import exec_pkg::*;

	// valid is a level, the fields hold steady while it is high
	logic valid;
	tag_t tag;
	value_t value;
	logic dbz;
	// Single cycle pulse from the arbiter, the lane drops valid on it
	logic take;

	modport lane (output valid, tag, value, dbz, input take);
	modport arbiter (input valid, tag, value, dbz, output take);

endinterface

`default_nettype wire

//--- hw/issue_if.sv
/*
 * Issue channel from the dispatcher into one execute lane
 */
`timescale 1ns/100ps
`default_nettype none

interface issue_if;
	import isa_pkg::*;
	import exec_pkg::*;

	// One cycle strobe, the operand fields are valid while it is high
	logic start;
	instruction_t ir;
	value_t a, b, c, t, i, p;
	tag_t tag;
	// High from the start strobe until the lane result is taken
	logic busy;

	modport dispatch (output start, ir, a, b, c, t, i, p, tag, input busy);
	modport lane (input start, ir, a, b, c, t, i, p, tag, output busy);

endinterface

`default_nettype wire

//--- hw/exec_pkg.sv
/*
 * Cluster bookkeeping types: result tags and FSM state encodings
 */
`default_nettype none

package exec_pkg;

	// Tag given at issue and returned with the result
	typedef logic [3:0] tag_t;

	// Lane FSM, HOLD keeps the result up until the arbiter takes it
	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_MUL,
		LANE_DIV,
		LANE_HOLD
	} lane_state_t;

	// Divider FSM
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

endpackage

`default_nettype wire

//--- hw/isa_pkg.sv
/*
 * Instruction set definitions for the integer execute cluster.
 * Word widths, field positions, opcode and function codes.
 */
`default_nettype none

package isa_pkg;

	// ======================================================================
	// Widths and field positions
	// ======================================================================
	localparam int VALUE_W = 64;
	localparam int INSN_W = 32;
	// The major opcode sits in the low bits and the function code above it
	localparam int OPCODE_LSB = 0;
	localparam int FUNC_LSB = 6;

	typedef logic [VALUE_W-1:0] value_t;
	typedef logic [2*VALUE_W-1:0] double_value_t;
	typedef logic [INSN_W-1:0] instruction_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] func_t;

	// ======================================================================
	// Major opcodes
	// ======================================================================
	localparam opcode_t OP_R2 = 6'h02;
	localparam opcode_t OP_ADDI = 6'h04;
	localparam opcode_t OP_CMPI = 6'h05;
	localparam opcode_t OP_MULI = 6'h06;
	localparam opcode_t OP_MULUI = 6'h07;
	localparam opcode_t OP_ANDI = 6'h08;
	localparam opcode_t OP_ORI = 6'h09;
	localparam opcode_t OP_EORI = 6'h0A;
	localparam opcode_t OP_SLTI = 6'h0B;
	localparam opcode_t OP_DIVI = 6'h0C;
	localparam opcode_t OP_DIVUI = 6'h0D;
	localparam opcode_t OP_MOV = 6'h10;
	// Indexed address forming, the load itself happens elsewhere
	localparam opcode_t OP_LDX = 6'h20;
	localparam opcode_t OP_BLEND = 6'h28;

	// Register form function codes, only valid under OP_R2
	localparam func_t FN_ADD = 6'h04;
	localparam func_t FN_SUB = 6'h05;
	localparam func_t FN_CMP = 6'h06;
	localparam func_t FN_AND = 6'h08;
	localparam func_t FN_OR = 6'h09;
	localparam func_t FN_EOR = 6'h0A;
	localparam func_t FN_ANDC = 6'h0B;
	localparam func_t FN_NAND = 6'h0C;
	localparam func_t FN_NOR = 6'h0D;
	localparam func_t FN_ENOR = 6'h0E;
	localparam func_t FN_ORC = 6'h0F;
	localparam func_t FN_MUL = 6'h10;
	localparam func_t FN_MULU = 6'h11;
	localparam func_t FN_MULH = 6'h12;
	localparam func_t FN_MULUH = 6'h13;
	localparam func_t FN_DIV = 6'h14;
	localparam func_t FN_DIVU = 6'h15;
	localparam func_t FN_MOD = 6'h16;
	localparam func_t FN_MODU = 6'h17;
	localparam func_t FN_SEQ = 6'h18;
	localparam func_t FN_SNE = 6'h19;
	localparam func_t FN_SLT = 6'h1A;
	localparam func_t FN_SLE = 6'h1B;
	localparam func_t FN_SLTU = 6'h1C;
	localparam func_t FN_SLEU = 6'h1D;

	// Filler returned for any code the lane does not know
	localparam value_t BAD_RESULT = {2{32'hDEADBEEF}};

endpackage

`default_nettype wire
